//--- list.f
logic/corep.sv
logic/distram_1rport_1wport.sv
logic/ibtb.sv
logic/ibtb_update_router.sv
logic/ibtb_hit_select.sv
logic/ibtb_top.sv
test/ibtb_tb.sv

//--- logic/corep.sv
// shared sizes, types and helper functions of the indirect BTB subsystem
// every IBTB file refers to these by scoped name (corep::name)
// pc layout: [1:0] lane/bank, [7:2] index hash, [17:8] tag

`default_nettype none

package corep;

    // ----------------------------------------
    // sizes
    // ----------------------------------------

    localparam int PC_BITS   = 38;
    localparam int GH_BITS   = 8;
    localparam int ASID_BITS = 9;

    // banks chosen by lane bits of the pc
    localparam int IBTB_BANKS     = 4;
    localparam int IBTB_BANK_BITS = $clog2(IBTB_BANKS);

    // sets per bank
    localparam int IBTB_SETS     = 64;
    localparam int IBTB_IDX_BITS = $clog2(IBTB_SETS);
    localparam int IBTB_TAG_BITS = 10;

    // field positions inside the pc
    localparam int IBTB_IDX_LSB = IBTB_BANK_BITS;
    localparam int IBTB_TAG_LSB = IBTB_IDX_LSB + IBTB_IDX_BITS;

    // ----------------------------------------
    // types
    // ----------------------------------------

    typedef logic [PC_BITS-1:0]        pc38_t;
    typedef logic [GH_BITS-1:0]        ibtb_gh_t;
    typedef logic [ASID_BITS-1:0]      asid_t;
    typedef logic [IBTB_BANK_BITS-1:0] ibtb_bank_t;
    typedef logic [IBTB_IDX_BITS-1:0]  ibtb_idx_t;
    typedef logic [IBTB_TAG_BITS-1:0]  ibtb_tag_t;

    // one RAM word: tag over target, 48 bits
    typedef struct packed {
        ibtb_tag_t tag;
        pc38_t     tgt;
    } ibtb_info_t;

    // ----------------------------------------
    // helpers
    // ----------------------------------------

    // lane bits pick the bank
    function automatic ibtb_bank_t bank_of(pc38_t pc38);
        bank_of = pc38[IBTB_BANK_BITS-1:0];
    endfunction

    // upper pc bits kept as tag
    function automatic ibtb_tag_t tag_of(pc38_t pc38);
        tag_of = pc38[IBTB_TAG_LSB +: IBTB_TAG_BITS];
    endfunction

    // pc[7:2] ^ low gh ^ low asid
    // lane bits excluded, they already chose the bank
    function automatic ibtb_idx_t index_hash(pc38_t pc38, ibtb_gh_t gh, asid_t asid);
        ibtb_idx_t idx;
        idx = pc38[IBTB_IDX_LSB +: IBTB_IDX_BITS];
        idx ^= gh[IBTB_IDX_BITS-1:0];
        idx ^= asid[IBTB_IDX_BITS-1:0];
        index_hash = idx;
    endfunction

endpackage

`default_nettype wire

//--- logic/distram_1rport_1wport.sv
// generic LUT-RAM style array, one read port and one write port
// read is combinational, write lands on the rising edge of CLK
// no reset on the storage, callers track validity themselves

`default_nettype none

module distram_1rport_1wport #(
    parameter int ENTRIES = 64,
    parameter int WIDTH   = 48
) (
    input  wire logic                       CLK,

    // read port
    input  wire logic [$clog2(ENTRIES)-1:0] rindex,
    output logic      [WIDTH-1:0]           rdata,

    // write port
    input  wire logic                       wen,
    input  wire logic [$clog2(ENTRIES)-1:0] windex,
    input  wire logic [WIDTH-1:0]           wdata
);

    // storage
    logic [WIDTH-1:0] mem [ENTRIES];

    // async read
    assign rdata = mem[rindex];

    // clocked write
    always_ff @(posedge CLK) begin
        if (wen) begin
            mem[windex] <= wdata;
        end
    end

endmodule

`default_nettype wire

//--- logic/ibtb.sv
// one indirect BTB bank
// hashes read and write set indexes, keeps a per-set valid vector
// and stores tag plus target in a distributed RAM
// read outputs are combinational from the live lookup inputs

`default_nettype none

module ibtb (
    input  wire logic             CLK,
    input  wire logic             rst_n,

    // arch state
    input  wire corep::asid_t     arch_asid,

    // lookup
    input  wire corep::pc38_t     read_src_pc38,
    input  wire corep::ibtb_gh_t  read_ibtb_gh,
    output corep::ibtb_info_t     read_entry,
    output logic                  read_entry_valid,

    // update, already steered to this bank
    input  wire logic             wen,
    input  wire corep::pc38_t     upd_pc38,
    input  wire corep::ibtb_gh_t  upd_gh,
    input  wire corep::pc38_t     upd_tgt_pc38
);

    // ----------------------------------------
    // index and data
    // ----------------------------------------

    corep::ibtb_idx_t  ridx;
    corep::ibtb_idx_t  widx;
    corep::ibtb_info_t wentry;

    // same asid for both ports, no asid tagging
    assign ridx = corep::index_hash(read_src_pc38, read_ibtb_gh, arch_asid);
    assign widx = corep::index_hash(upd_pc38, upd_gh, arch_asid);

    // entry written: tag of the branch pc, then its target
    always_comb begin
        wentry.tag = corep::tag_of(upd_pc38);
        wentry.tgt = upd_tgt_pc38;
    end

    // ----------------------------------------
    // valid vector
    // ----------------------------------------

    logic [corep::IBTB_SETS-1:0] valid_q;

    // only reset state of the bank
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (wen) begin
            valid_q[widx] <= 1'b1;
        end
    end

    assign read_entry_valid = valid_q[ridx];

    // ----------------------------------------
    // storage
    // ----------------------------------------

    distram_1rport_1wport #(
        .ENTRIES(corep::IBTB_SETS),
        .WIDTH  ($bits(corep::ibtb_info_t))
    ) array_i (
        .CLK   (CLK),
        .rindex(ridx),
        .rdata (read_entry),
        .wen   (wen),
        .windex(widx),
        .wdata (wentry)
    );

endmodule

`default_nettype wire

//--- logic/ibtb_hit_select.sv
// hit selector at the read side of the IBTB banks
// captures the lookup and every bank's entry at one edge, then in the
// next cycle picks the addressed bank, compares tags, drives hit/target
// one lookup per cycle, latency one

`default_nettype none

module ibtb_hit_select (
    input  wire logic                                         CLK,
    input  wire logic                                         rst_n,

    // lookup
    input  wire logic                                         read_valid,
    input  wire corep::pc38_t                                 read_src_pc38,

    // all banks, combinational from the arrays
    input  wire corep::ibtb_info_t [corep::IBTB_BANKS-1:0]    bank_entry,
    input  wire logic [corep::IBTB_BANKS-1:0]                 bank_entry_valid,

    // result
    output logic                                              read_out_valid,
    output logic                                              read_hit,
    output corep::pc38_t                                      read_tgt_pc38
);

    // ----------------------------------------
    // lookup stage
    // ----------------------------------------

    logic                                        valid_q;
    logic [corep::IBTB_BANKS-1:0]                entry_valid_q;
    corep::ibtb_bank_t                           bank_q;
    corep::ibtb_tag_t                            tag_q;
    corep::ibtb_info_t [corep::IBTB_BANKS-1:0]   entry_q;

    // control, cleared by reset
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            valid_q       <= 1'b0;
            entry_valid_q <= '0;
        end else begin
            valid_q       <= read_valid;
            entry_valid_q <= bank_entry_valid;
        end
    end

    // payload
    always_ff @(posedge CLK) begin
        bank_q  <= corep::bank_of(read_src_pc38);
        tag_q   <= corep::tag_of(read_src_pc38);
        entry_q <= bank_entry;
    end

    // ----------------------------------------
    // select and compare
    // ----------------------------------------

    corep::ibtb_info_t sel_entry;
    logic              tag_match;

    // bank picked by registered lane bits
    assign sel_entry = entry_q[bank_q];
    assign tag_match = (sel_entry.tag == tag_q);

    assign read_out_valid = valid_q;
    assign read_hit       = valid_q & entry_valid_q[bank_q] & tag_match;
    // target meaningless on a miss
    assign read_tgt_pc38  = sel_entry.tgt;

endmodule

`default_nettype wire

//--- logic/ibtb_top.sv
// top of the indirect BTB subsystem
// update router feeds the banks, banks feed the hit selector
// update stored two edges after it is presented, lookup latency one

`default_nettype none

module ibtb_top (
    input  wire logic             CLK,
    input  wire logic             rst_n,

    // arch state
    input  wire corep::asid_t     arch_asid,

    // lookup
    input  wire logic             read_valid,
    input  wire corep::pc38_t     read_src_pc38,
    input  wire corep::ibtb_gh_t  read_ibtb_gh,

    // update
    input  wire logic             update_valid,
    input  wire corep::pc38_t     update_src_pc38,
    input  wire corep::ibtb_gh_t  update_ibtb_gh,
    input  wire corep::pc38_t     update_tgt_pc38,

    // result
    output logic                  read_out_valid,
    output logic                  read_hit,
    output corep::pc38_t          read_tgt_pc38
);

    // ----------------------------------------
    // internal wires
    // ----------------------------------------

    // shared update bus
    logic [corep::IBTB_BANKS-1:0]               bank_wen;
    corep::pc38_t                               upd_pc38;
    corep::ibtb_gh_t                            upd_gh;
    corep::pc38_t                               upd_tgt_pc38;

    // bank read outputs
    corep::ibtb_info_t [corep::IBTB_BANKS-1:0]  bank_entry;
    logic [corep::IBTB_BANKS-1:0]               bank_entry_valid;

    // ----------------------------------------
    // update router
    // ----------------------------------------

    ibtb_update_router router_i (
        .CLK            (CLK),
        .rst_n          (rst_n),
        .update_valid   (update_valid),
        .update_src_pc38(update_src_pc38),
        .update_ibtb_gh (update_ibtb_gh),
        .update_tgt_pc38(update_tgt_pc38),
        .bank_wen       (bank_wen),
        .upd_pc38       (upd_pc38),
        .upd_gh         (upd_gh),
        .upd_tgt_pc38   (upd_tgt_pc38)
    );

    // banks, all see the live lookup
    for (genvar b = 0; b < corep::IBTB_BANKS; b++) begin : bank_g
        ibtb bank_i (
            .CLK             (CLK),
            .rst_n           (rst_n),
            .arch_asid       (arch_asid),
            .read_src_pc38   (read_src_pc38),
            .read_ibtb_gh    (read_ibtb_gh),
            .read_entry      (bank_entry[b]),
            .read_entry_valid(bank_entry_valid[b]),
            .wen             (bank_wen[b]),
            .upd_pc38        (upd_pc38),
            .upd_gh          (upd_gh),
            .upd_tgt_pc38    (upd_tgt_pc38)
        );
    end

    // ----------------------------------------
    // hit selector
    // ----------------------------------------

    ibtb_hit_select select_i (
        .CLK             (CLK),
        .rst_n           (rst_n),
        .read_valid      (read_valid),
        .read_src_pc38   (read_src_pc38),
        .bank_entry      (bank_entry),
        .bank_entry_valid(bank_entry_valid),
        .read_out_valid  (read_out_valid),
        .read_hit        (read_hit),
        .read_tgt_pc38   (read_tgt_pc38)
    );

endmodule

`default_nettype wire

//--- logic/ibtb_update_router.sv
// update router for the IBTB banks
// registers a resolved indirect branch for one cycle, then raises the
// write strobe of the bank picked by the lane bits of its pc
// payload goes out on a bus shared by all banks

`default_nettype none

module ibtb_update_router (
    input  wire logic                          CLK,
    input  wire logic                          rst_n,

    // resolved branch from execute
    input  wire logic                          update_valid,
    input  wire corep::pc38_t                  update_src_pc38,
    input  wire corep::ibtb_gh_t               update_ibtb_gh,
    input  wire corep::pc38_t                  update_tgt_pc38,

    // to banks
    output logic [corep::IBTB_BANKS-1:0]       bank_wen,
    output corep::pc38_t                       upd_pc38,
    output corep::ibtb_gh_t                    upd_gh,
    output corep::pc38_t                       upd_tgt_pc38
);

    // ----------------------------------------
    // bank decode
    // ----------------------------------------

    logic [corep::IBTB_BANKS-1:0] wen_d;

    // one-hot from lane bits, empty when no update
    always_comb begin
        wen_d = '0;
        if (update_valid) begin
            wen_d[corep::bank_of(update_src_pc38)] = 1'b1;
        end
    end

    // ----------------------------------------
    // pipeline stage
    // ----------------------------------------

    // strobe register, cleared by reset
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            bank_wen <= '0;
        end else begin
            bank_wen <= wen_d;
        end
    end

    // payload, qualified by bank_wen
    always_ff @(posedge CLK) begin
        upd_pc38     <= update_src_pc38;
        upd_gh       <= update_ibtb_gh;
        upd_tgt_pc38 <= update_tgt_pc38;
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the IBTB testbench with Verilator
# exit status is nonzero when the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module ibtb_tb \
    -f list.f \
    -o ibtb_sim \
    && ./obj_dir/ibtb_sim \
    && echo "simulation run ok" \
    || { echo "simulation or build failed"; exit 1; }

//--- test/ibtb_tb.sv
// testbench for the indirect BTB subsystem (ibtb_top)
// drives updates and lookups from a seeded Galois LFSR, mirrors the banks
// in a reference model and checks every result with concurrent assertions

`default_nettype none

module ibtb_tb;

    // ----------------------------------------
    // signals and run limits
    // ----------------------------------------

    // generous headroom over the directed plus random run
    localparam int MAX_CYCLES = 3000;
    localparam int RAND_OPS   = 400;

    logic            CLK;
    logic            rst_n;
    corep::asid_t    arch_asid;
    logic            read_valid;
    corep::pc38_t    read_src_pc38;
    corep::ibtb_gh_t read_ibtb_gh;
    logic            update_valid;
    corep::pc38_t    update_src_pc38;
    corep::ibtb_gh_t update_ibtb_gh;
    corep::pc38_t    update_tgt_pc38;
    logic            read_out_valid;
    logic            read_hit;
    corep::pc38_t    read_tgt_pc38;

    ibtb_top dut_i (
        .CLK            (CLK),
        .rst_n          (rst_n),
        .arch_asid      (arch_asid),
        .read_valid     (read_valid),
        .read_src_pc38  (read_src_pc38),
        .read_ibtb_gh   (read_ibtb_gh),
        .update_valid   (update_valid),
        .update_src_pc38(update_src_pc38),
        .update_ibtb_gh (update_ibtb_gh),
        .update_tgt_pc38(update_tgt_pc38),
        .read_out_valid (read_out_valid),
        .read_hit       (read_hit),
        .read_tgt_pc38  (read_tgt_pc38)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    int cycle_count = 0;

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Verification failed");
            $fatal(1, "timeout");
        end
    end

    // ----------------------------------------
    // random source
    // ----------------------------------------

    logic [15:0] lfsr_state = 16'd30;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            lfsr_next = (s >> 1) ^ 16'hB400;
        end else begin
            lfsr_next = s >> 1;
        end
    endfunction

    // one lfsr step per bit
    task automatic take_bits(input int n, output logic [63:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[62:0], lfsr_state[0]};
        end
    endtask

    // ----------------------------------------
    // reference model
    // ----------------------------------------

    logic [corep::IBTB_SETS-1:0] m_valid [corep::IBTB_BANKS];
    corep::ibtb_tag_t            m_tag   [corep::IBTB_BANKS][corep::IBTB_SETS];
    corep::pc38_t                m_tgt   [corep::IBTB_BANKS][corep::IBTB_SETS];

    // update held one edge, like the router
    logic            pend_valid;
    corep::pc38_t    pend_pc;
    corep::ibtb_gh_t pend_gh;
    corep::pc38_t    pend_tgt;

    // expected result of the lookup sampled at the last edge
    logic            exp_valid;
    logic            exp_hit;
    corep::pc38_t    exp_tgt;

    corep::ibtb_bank_t lk_bank;
    corep::ibtb_idx_t  lk_idx;
    logic              lk_hit;
    corep::ibtb_bank_t wr_bank;
    corep::ibtb_idx_t  wr_idx;
    int                hit_count = 0;

    always @(posedge CLK) begin
        if (!rst_n) begin
            m_valid    = '{default: '0};
            pend_valid = 1'b0;
            exp_valid <= 1'b0;
            exp_hit   <= 1'b0;
            exp_tgt   <= '0;
        end else begin
            // lookup reads contents from before this edge
            lk_bank = corep::bank_of(read_src_pc38);
            lk_idx  = corep::index_hash(read_src_pc38, read_ibtb_gh, arch_asid);
            lk_hit  = m_valid[lk_bank][lk_idx] &&
                      (m_tag[lk_bank][lk_idx] == corep::tag_of(read_src_pc38));
            exp_valid <= read_valid;
            exp_hit   <= read_valid && lk_hit;
            exp_tgt   <= m_tgt[lk_bank][lk_idx];
            if (read_valid && lk_hit) begin
                hit_count++;
            end
            // update registered one edge ago is written now, live asid
            if (pend_valid) begin
                wr_bank = corep::bank_of(pend_pc);
                wr_idx  = corep::index_hash(pend_pc, pend_gh, arch_asid);
                m_valid[wr_bank][wr_idx] = 1'b1;
                m_tag[wr_bank][wr_idx]   = corep::tag_of(pend_pc);
                m_tgt[wr_bank][wr_idx]   = pend_tgt;
            end
            pend_valid = update_valid;
            pend_pc    = update_src_pc38;
            pend_gh    = update_ibtb_gh;
            pend_tgt   = update_tgt_pc38;
        end
    end

    // ----------------------------------------
    // checks
    // ----------------------------------------

    task automatic fail_value(input string msg);
        $display("FAIL at %0t: %s", $time, msg);
        $display("Verification failed");
        $fatal(1, "check failed");
    endtask

    // result exactly one cycle after the lookup
    valid_check: assert property (@(posedge CLK) disable iff (!rst_n)
        read_out_valid == exp_valid)
        else fail_value($sformatf("read_out_valid %0b, expected %0b",
                                  $sampled(read_out_valid), $sampled(exp_valid)));

    // hit also low in cycles without a result
    hit_check: assert property (@(posedge CLK) disable iff (!rst_n)
        read_hit == exp_hit)
        else fail_value($sformatf("read_hit %0b, expected %0b",
                                  $sampled(read_hit), $sampled(exp_hit)));

    // target only defined on a hit
    tgt_check: assert property (@(posedge CLK) disable iff (!rst_n)
        (read_out_valid && exp_hit) |-> read_tgt_pc38 == exp_tgt)
        else fail_value($sformatf("read_tgt_pc38 %h, expected %h",
                                  $sampled(read_tgt_pc38), $sampled(exp_tgt)));

    // ----------------------------------------
    // stimulus
    // ----------------------------------------

    // inputs change 10 units after the edge, strobes drop by default
    task automatic step();
        @(posedge CLK);
        #10;
        read_valid   = 1'b0;
        update_valid = 1'b0;
    endtask

    task automatic drive_update(input corep::pc38_t pc, input corep::ibtb_gh_t gh,
                                input corep::pc38_t tgt);
        update_valid    = 1'b1;
        update_src_pc38 = pc;
        update_ibtb_gh  = gh;
        update_tgt_pc38 = tgt;
    endtask

    task automatic drive_lookup(input corep::pc38_t pc, input corep::ibtb_gh_t gh);
        read_valid    = 1'b1;
        read_src_pc38 = pc;
        read_ibtb_gh  = gh;
    endtask

    logic [63:0]     r;
    logic [63:0]     s;
    int              burst_len;
    corep::pc38_t    pc_a;
    corep::pc38_t    pc_b;
    corep::ibtb_gh_t gh_a;
    corep::pc38_t    pool_pc [16];
    corep::ibtb_gh_t pool_gh [16];

    initial begin
        rst_n           = 1'b0;
        arch_asid       = 9'h015;
        read_valid      = 1'b0;
        read_src_pc38   = '0;
        read_ibtb_gh    = '0;
        update_valid    = 1'b0;
        update_src_pc38 = '0;
        update_ibtb_gh  = '0;
        update_tgt_pc38 = '0;
        repeat (5) @(posedge CLK);
        #10;
        rst_n = 1'b1;

        // idle, then lookups into an empty table
        repeat (3) step();
        for (int i = 0; i < 8; i++) begin
            take_bits(46, r);
            drive_lookup(r[37:0], r[45:38]);
            step();
        end

        // write then read two cycles later
        take_bits(46, r);
        pc_a = r[37:0];
        gh_a = r[45:38];
        take_bits(38, r);
        drive_update(pc_a, gh_a, r[37:0]);
        step();
        step();
        drive_lookup(pc_a, gh_a);
        step();

        // same set other tag, then moved index by gh and asid
        drive_lookup(pc_a ^ (38'h3ff << 8), gh_a);
        step();
        drive_lookup(pc_a, gh_a ^ 8'h01);
        step();
        arch_asid = arch_asid ^ 9'h004;
        drive_lookup(pc_a, gh_a);
        step();
        arch_asid = arch_asid ^ 9'h004;

        // same index and tag across all four lanes
        take_bits(46, r);
        for (int lane = 0; lane < 4; lane++) begin
            take_bits(38, s);
            drive_update(corep::pc38_t'({r[37:2], 2'(lane)}), r[45:38], s[37:0]);
            step();
        end
        step();
        for (int lane = 0; lane < 4; lane++) begin
            drive_lookup(corep::pc38_t'({r[37:2], 2'(lane)}), r[45:38]);
            step();
        end

        // overwrite of one set by a second tag
        take_bits(46, r);
        pc_a = r[37:0];
        gh_a = r[45:38];
        pc_b = pc_a ^ (38'h155 << 8);
        take_bits(38, s);
        drive_update(pc_a, gh_a, s[37:0]);
        step();
        take_bits(38, s);
        drive_update(pc_b, gh_a, s[37:0]);
        step();
        step();
        drive_lookup(pc_b, gh_a);
        step();
        drive_lookup(pc_a, gh_a);
        step();

        // random mix, odd pool entries share a set with the even one
        for (int i = 0; i < 16; i += 2) begin
            take_bits(46, r);
            pool_pc[i]     = r[37:0];
            pool_gh[i]     = r[45:38];
            pool_pc[i + 1] = r[37:0] ^ (38'h2a5 << 8);
            pool_gh[i + 1] = r[45:38];
        end
        for (int n = 0; n < RAND_OPS; n++) begin
            take_bits(5, r);
            if (r[4:0] == 5'd0) begin
                take_bits(9, s);
                arch_asid = s[8:0];
            end
            take_bits(2, r);
            if (r[1:0] != 2'd1) begin
                take_bits(42, s);
                drive_update(pool_pc[s[41:38]], pool_gh[s[41:38]], s[37:0]);
            end
            if (r[1:0] != 2'd0) begin
                take_bits(9, s);
                drive_lookup(pool_pc[s[3:0]], s[4] ? pool_gh[s[8:5]] : pool_gh[s[3:0]]);
            end
            step();
            // burst of back-to-back lookups
            if (r[1:0] == 2'd3) begin
                take_bits(2, s);
                burst_len = int'(s[1:0]);
                for (int k = 0; k <= burst_len; k++) begin
                    take_bits(4, s);
                    drive_lookup(pool_pc[s[3:0]], pool_gh[s[3:0]]);
                    step();
                end
            end
        end
        repeat (3) step();

        if (hit_count == 0) begin
            $display("no lookup ever hit, stimulus did not reach the hit checks");
            $display("Verification failed");
            $fatal(1, "no hits");
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

`default_nettype wire
